// File: wisc.f
+incdir+tests
hdl/wiscPkg.sv
hdl/control.sv
hdl/aluUnit.sv
hdl/apbDataPort.sv
hdl/writeBack.sv
hdl/regFile.sv
hdl/pcUnit.sv
hdl/wiscCore.sv
tests/wiscCoreTb.sv

// File: Bender.yml
package:
  name: wisc

sources:
  - files:
      - hdl/wiscPkg.sv
      - hdl/control.sv
      - hdl/aluUnit.sv
      - hdl/apbDataPort.sv
      - hdl/writeBack.sv
      - hdl/regFile.sv
      - hdl/pcUnit.sv
      - hdl/wiscCore.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/wiscCoreTb.sv

// File: tests/wiscCoreTests.svh
function automatic logic [15:0] satArith(input logic [15:0] a, input logic [15:0] b,
                                         input logic sub);
    int sa;
    int sb;
    int r;
    sa = int'($signed(a));
    sb = int'($signed(b));
    r = sub ? sa - sb : sa + sb;
    if (r > 32767)
        r = 32767;
    else if (r < -32768)
        r = -32768;
    return r[15:0];
endfunction

// Returns {Z, N, V} after a SUB
function automatic logic [2:0] subFlags(input logic [15:0] a, input logic [15:0] b);
    int          r;
    logic [15:0] res;
    r = int'($signed(a)) - int'($signed(b));
    res = satArith(a, b, 1'b1);
    return {res == 16'h0000, res[15], (r > 32767) || (r < -32768)};
endfunction

function automatic logic condTaken(input logic [2:0] ccc, input logic [2:0] f);
    case (ccc)
        wiscPkg::CcNe: return !f[2];
        wiscPkg::CcEq: return f[2];
        wiscPkg::CcGt: return !f[2] && !f[1];
        wiscPkg::CcLt: return f[1];
        wiscPkg::CcGe: return f[2] || !f[1];
        wiscPkg::CcLe: return f[2] || f[1];
        wiscPkg::CcOv: return f[0];
        default:       return 1'b1;
    endcase
endfunction

function automatic logic [15:0] shiftModel(input logic [3:0] op, input logic [15:0] a,
                                           input int sh);
    logic [15:0] r;
    for (int i = 0; i < 16; i++) begin
        if (op == wiscPkg::OpRor)
            r[i] = a[(i + sh) % 16];
        else if (op == wiscPkg::OpSra)
            r[i] = (i + sh < 16) ? a[i + sh] : a[15]; // Sign fill
        else
            r[i] = (i >= sh) ? a[i - sh] : 1'b0;
    end
    return r;
endfunction

function automatic logic [15:0] paddsbModel(input logic [15:0] a, input logic [15:0] b);
    logic [15:0] r;
    int          s;
    for (int i = 0; i < 4; i++) begin
        s = int'($signed(a[4*i+:4])) + int'($signed(b[4*i+:4]));
        s = (s > 7) ? 7 : (s < -8) ? -8 : s;
        r[4*i+:4] = s[3:0];
    end
    return r;
endfunction

task automatic resetState();
    startProgram();
    loadValue(4'd1, 16'h1234);
    storeChecked(4'd1, 4'd0, 16'h0000, 4'd3, 16'h1234);
    emitHalt();
    runProgram();
endtask

task automatic registerArithmetic();
    logic [15:0] opA [5];
    logic [15:0] opB [5];
    logic [3:0]  aluOps [4];
    logic [15:0] res;
    startProgram();
    opA = '{16'h0000, 16'h7FF0, 16'h8001, 16'h8010, 16'h7FFF}; // Saturating pairs after the first
    opB = '{16'h0000, 16'h0020, 16'hFFF0, 16'h0020, 16'hFFFF};
    opA[0] = lcgNext();
    opB[0] = lcgNext();
    aluOps = '{wiscPkg::OpAdd, wiscPkg::OpSub, wiscPkg::OpXor, wiscPkg::OpAnd};
    for (int i = 0; i < 5; i++) begin
        loadValue(4'd1, opA[i]);
        loadValue(4'd2, opB[i]);
        for (int k = 0; k < 4; k++)
            prog.push_back({aluOps[k], 4'(3 + k), 4'd1, 4'd2});
        for (int k = 0; k < 4; k++) begin
            case (k)
                0:       res = satArith(opA[i], opB[i], 1'b0);
                1:       res = satArith(opA[i], opB[i], 1'b1);
                2:       res = opA[i] ^ opB[i];
                default: res = opA[i] & opB[i];
            endcase
            storeChecked(4'(3 + k), 4'd0, 16'h0000, 4'(4 * i + k), res);
        end
    end
    emitHalt();
    runProgram();
endtask

task automatic shiftsAndPaddsb();
    logic [15:0] val [2];
    logic [3:0]  shOps [3];
    int          amounts [4];
    logic [15:0] pa [2];
    logic [15:0] pb [2];
    int          off;
    startProgram();
    val = '{16'h8F31, lcgNext()};
    shOps = '{wiscPkg::OpSll, wiscPkg::OpSra, wiscPkg::OpRor};
    amounts = '{1, 4, 9, 15};
    pa = '{16'h7878, lcgNext()};
    pb = '{16'h1818, lcgNext()};
    off = 0;
    for (int v = 0; v < 2; v++) begin
        loadValue(4'd1, val[v]);
        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o < 3; o++) begin
                prog.push_back({shOps[o], 4'd3, 4'd1, 4'(amounts[s])});
                storeChecked(4'd3, 4'd0, 16'h0000, 4'(off),
                             shiftModel(shOps[o], val[v], amounts[s]));
                off++;
            end
        end
    end
    for (int p = 0; p < 2; p++) begin
        loadValue(4'd1, pa[p]);
        loadValue(4'd2, pb[p]);
        prog.push_back({wiscPkg::OpPaddsb, 4'd3, 4'd1, 4'd2});
        storeChecked(4'd3, 4'd0, 16'h0000, 4'(off), paddsbModel(pa[p], pb[p]));
        off++;
    end
    emitHalt();
    runProgram();
endtask

task automatic memoryRoundTrip();
    logic [15:0] words [4];
    logic [3:0]  offs [4];
    logic [15:0] base;
    startProgram();
    base = 16'h0100;
    offs = '{4'd1, 4'd6, 4'd11, 4'd15};
    loadValue(4'd5, base);
    for (int k = 0; k < 4; k++) begin
        words[k] = lcgNext();
        loadValue(4'd1, words[k]);
        storeChecked(4'd1, 4'd5, base, offs[k], words[k]);
    end
    for (int k = 0; k < 4; k++) begin
        prog.push_back({wiscPkg::OpLw, 4'd2, 4'd5, offs[k]});
        storeChecked(4'd2, 4'd0, 16'h0000, 4'(k), words[k]); // Echo the loaded word
    end
    emitHalt();
    runProgram();
endtask

task automatic controlFlow();
    logic [15:0] setA [4];
    logic [15:0] setB [4];
    logic [2:0]  f;
    logic [15:0] marker;
    int          target;
    startProgram();
    setA = '{16'd5, 16'd3, 16'd5, 16'h8000};
    setB = '{16'd5, 16'd5, 16'd3, 16'h0001};
    marker = lcgNext();
    loadValue(4'd9, marker);
    for (int s = 0; s < 4; s++) begin
        loadValue(4'd1, setA[s]);
        loadValue(4'd2, setB[s]);
        prog.push_back({wiscPkg::OpSub, 4'd3, 4'd1, 4'd2});
        f = subFlags(setA[s], setB[s]);
        for (int c = 0; c < 8; c++) begin
            prog.push_back({wiscPkg::OpB, 3'(c), 9'd1}); // Taken skips one word
            if (condTaken(3'(c), f))
                emitStore(4'd9, 4'd0, 4'(2 * c));
            else
                storeChecked(4'd9, 4'd0, 16'h0000, 4'(2 * c), marker);
            storeChecked(4'd9, 4'd0, 16'h0000, 4'(2 * c + 1), marker);
        end
    end
    target = prog.size() + 4; // LLB, LHB, BR, skipped store
    loadValue(4'd11, 16'(2 * target));
    prog.push_back({wiscPkg::OpBr, wiscPkg::CcAlways, 1'b0, 4'd11, 4'd0});
    emitStore(4'd9, 4'd0, 4'd15);
    prog.push_back({wiscPkg::OpPcs, 4'd10, 8'd0});
    storeChecked(4'd10, 4'd0, 16'h0000, 4'd0, 16'(2 * target + 2));
    emitHalt();
    runProgram();
endtask

task automatic haltBehavior();
    logic [15:0] value;
    logic [15:0] haltPc;
    startProgram();
    value = lcgNext();
    loadValue(4'd1, value);
    storeChecked(4'd1, 4'd0, 16'h0000, 4'd2, value);
    haltPc = 16'(2 * prog.size());
    emitHalt();
    emitStore(4'd1, 4'd0, 4'd3); // Behind the HLT
    cycleBudget += HoldCycles;
    runProgram();
    repeat (HoldCycles) begin
        @(negedge clk);
        checkEq("halted", halted, 1'b1);
        checkEq("psel", psel, 1'b0);
        checkEq("instrAddr", instrAddr, haltPc);
    end
    compareLog();
endtask

// File: tests/wiscCoreTb.sv
`timescale 1ns/1ps

module wiscCoreTb;

    localparam int ClkPeriod   = 100;
    localparam int ResetCycles = 16;
    localparam int WorstCycles = 5;   // Load or store with three wait states
    localparam int HoldCycles  = 20;
    localparam int ImemWords   = 256;
    localparam int DmemWords   = 256;

    logic                          clk;
    logic                          rstN;
    logic [wiscPkg::DataWidth-1:0] instrAddr;
    logic [wiscPkg::DataWidth-1:0] instrData;
    logic [wiscPkg::DataWidth-1:0] paddr;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [wiscPkg::DataWidth-1:0] pwdata;
    logic [wiscPkg::DataWidth-1:0] prdata;
    logic                          pready;
    logic                          halted;

    logic [15:0] imem [ImemWords];
    logic [15:0] dmem [DmemWords];
    logic [15:0] prog [$];
    logic [15:0] logAddr [$];
    logic [15:0] logData [$];
    logic [15:0] expAddr [$];
    logic [15:0] expData [$];
    logic [31:0] lcgState = 32'd30;
    int          waitLeft = 0;
    int          cycles = 0;
    int          cycleBudget = 0;

    wiscCore u_dut (
        .clk, .rstN, .instrAddr, .instrData,
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .halted
    );

    assign instrData = imem[instrAddr[8:1]]; // Byte address to word index

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleBudget) begin
            $display("Timeout: the core did not halt within %0d cycles", cycleBudget);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    function automatic logic [15:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];
    endfunction

    // APB slave with 0 to 3 wait states per transfer
    always @(negedge clk) begin
        if (rstN && psel && !penable) begin
            waitLeft = lcgNext() % 4;
            pready <= 1'b0;
        end else if (rstN && psel && penable) begin
            if (waitLeft == 0) begin
                pready <= 1'b1;
                prdata <= dmem[paddr[8:1]];
                if (pwrite) begin
                    dmem[paddr[8:1]] = pwdata;
                    logAddr.push_back(paddr);
                    logData.push_back(pwdata);
                end
            end else begin
                waitLeft--;
                pready <= 1'b0;
            end
        end else begin
            pready <= 1'b0;
        end
    end

    task automatic checkEq(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic startProgram();
        prog.delete();
        expAddr.delete();
        expData.delete();
    endtask

    task automatic loadValue(input logic [3:0] rd, input logic [15:0] value);
        prog.push_back({wiscPkg::OpLlb, rd, value[7:0]});
        prog.push_back({wiscPkg::OpLhb, rd, value[15:8]});
    endtask

    task automatic emitStore(input logic [3:0] rd, input logic [3:0] rs, input logic [3:0] off);
        prog.push_back({wiscPkg::OpSw, rd, rs, off});
    endtask

    task automatic expectWrite(input logic [15:0] addr, input logic [15:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic storeChecked(input logic [3:0] rd, input logic [3:0] rs,
                                input logic [15:0] rsVal, input logic [3:0] off,
                                input logic [15:0] data);
        emitStore(rd, rs, off);
        expectWrite(rsVal + {off, 1'b0}, data); // Word address rs + 2*imm4
    endtask

    task automatic emitHalt();
        prog.push_back({wiscPkg::OpHlt, 12'h000});
    endtask

    task automatic compareLog();
        checkEq("write count", logAddr.size(), expAddr.size());
        for (int i = 0; i < expAddr.size(); i++) begin
            checkEq("paddr", logAddr[i], expAddr[i]);
            checkEq("pwdata", logData[i], expData[i]);
        end
    endtask

    // Reset is held while the new program is loaded
    task automatic runProgram();
        rstN = 1'b0;
        for (int i = 0; i < ImemWords; i++) begin
            if (i < prog.size())
                imem[i] = prog[i];
            else
                imem[i] = {wiscPkg::OpHlt, 12'(i)};
        end
        logAddr.delete();
        logData.delete();
        cycleBudget += prog.size() * WorstCycles + ResetCycles;
        repeat (ResetCycles) begin
            @(negedge clk);
            checkEq("psel", psel, 1'b0);
            checkEq("penable", penable, 1'b0);
            checkEq("pwrite", pwrite, 1'b0);
            checkEq("halted", halted, 1'b0);
            checkEq("instrAddr", instrAddr, 16'h0000);
        end
        rstN = 1'b1;
        while (!halted)
            @(negedge clk);
        compareLog();
    endtask

    `include "wiscCoreTests.svh"

    initial begin
        rstN   = 1'b0;
        prdata = '0;
        pready = 1'b0;
        resetState();
        registerArithmetic();
        shiftsAndPaddsb();
        memoryRoundTrip();
        controlFlow();
        haltBehavior();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: hdl/wiscCore.sv
`timescale 1ns/1ps

module wiscCore (
    input  logic                          clk,
    input  logic                          rstN,
    output logic [wiscPkg::DataWidth-1:0] instrAddr,
    input  logic [wiscPkg::DataWidth-1:0] instrData,
    output logic [wiscPkg::DataWidth-1:0] paddr,
    output logic                          psel,
    output logic                          penable,
    output logic                          pwrite,
    output logic [wiscPkg::DataWidth-1:0] pwdata,
    input  logic [wiscPkg::DataWidth-1:0] prdata,
    input  logic                          pready,
    output logic                          halted
);

    logic                          regDst;
    logic                          branch;
    logic                          branchReg;
    logic                          memToReg;
    logic                          memRead;
    logic                          aluSrc;
    logic                          memWrite;
    logic                          memHalf;
    logic                          regWrite;
    logic                          pcSave;
    logic [wiscPkg::DataWidth-1:0] rdDataA;
    logic [wiscPkg::DataWidth-1:0] rdDataB;
    logic [wiscPkg::DataWidth-1:0] aluResult;
    logic [2:0]                    flags;
    logic [wiscPkg::DataWidth-1:0] memData;
    logic                          stall;
    logic [wiscPkg::DataWidth-1:0] wrData;
    logic                          wrEn;
    logic [wiscPkg::DataWidth-1:0] pcPlus2;

    control uControl (
        .opcode(instrData[15:12]), .regDst, .branch, .branchReg, .memToReg, .memRead,
        .aluSrc, .memWrite, .memHalf, .regWrite, .pcSave
    );

    regFile uRegFile (
        .clk, .rstN,
        .rdAddrA(instrData[7:4]),                              // rs
        .rdAddrB(regDst ? instrData[3:0] : instrData[11:8]),   // rt or rd
        .rdDataA, .rdDataB,
        .wrAddr (instrData[11:8]),
        .wrData, .wrEn
    );

    aluUnit uAlu (
        .clk, .rstN,
        .opcode(instrData[15:12]),
        .srcA  (rdDataA),
        .srcB  (rdDataB),
        .imm4  (instrData[3:0]),
        .aluSrc, .memRead, .stall, .halted, .aluResult, .flags
    );

    apbDataPort uApb (
        .clk, .rstN, .memRead, .memWrite,
        .addr     (aluResult),
        .storeData(rdDataB),
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .memData, .stall,
        .memDone  ()
    );

    writeBack uWriteBack (
        .opcode  (instrData[15:12]),
        .regWrite, .memToReg, .memHalf, .pcSave, .stall, .aluResult, .memData,
        .oldValue(rdDataB),
        .imm8    (instrData[7:0]),
        .pcPlus2, .wrData, .wrEn
    );

    pcUnit uPc (
        .clk, .rstN,
        .opcode   (instrData[15:12]),
        .branch, .branchReg, .stall,
        .cond     (instrData[11:9]),
        .imm9     (instrData[8:0]),
        .flags,
        .regTarget(rdDataA),
        .pc       (instrAddr),
        .pcPlus2, .halted
    );

endmodule

// File: hdl/pcUnit.sv
`timescale 1ns/1ps

module pcUnit (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [wiscPkg::OpcodeWidth-1:0] opcode,
    input  logic                          branch,
    input  logic                          branchReg,
    input  logic                          stall,
    input  logic [2:0]                    cond,
    input  logic [8:0]                    imm9,
    input  logic [2:0]                    flags,
    input  logic [wiscPkg::DataWidth-1:0] regTarget,
    output logic [wiscPkg::DataWidth-1:0] pc,
    output logic [wiscPkg::DataWidth-1:0] pcPlus2,
    output logic                          halted
);

    logic                          condMet;
    logic                          isHlt;
    logic [wiscPkg::DataWidth-1:0] nextPc;
    logic                          z;
    logic                          v;
    logic                          n;

    assign z = flags[wiscPkg::FlagZ];
    assign v = flags[wiscPkg::FlagV];
    assign n = flags[wiscPkg::FlagN];

    always_comb begin
        case (cond)
            wiscPkg::CcNe: condMet = ~z;
            wiscPkg::CcEq: condMet = z;
            wiscPkg::CcGt: condMet = ~z & ~n;
            wiscPkg::CcLt: condMet = n;
            wiscPkg::CcGe: condMet = z | ~n;
            wiscPkg::CcLe: condMet = z | n;
            wiscPkg::CcOv: condMet = v;
            default:       condMet = 1'b1;
        endcase
    end

    assign isHlt   = (opcode == wiscPkg::OpHlt);
    assign pcPlus2 = pc + wiscPkg::DataWidth'(2);

    always_comb begin
        if (branch && condMet)
            nextPc = branchReg ? regTarget : pcPlus2 + {{6{imm9[8]}}, imm9, 1'b0};
        else
            nextPc = pcPlus2;
    end

    // PC parks on the HLT word so nothing else gets decoded
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            pc <= '0;
        else if (!stall && !halted && !isHlt)
            pc <= nextPc;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            halted <= 1'b0;
        else if (isHlt)
            halted <= 1'b1; // Sticky until reset
    end

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [wiscPkg::RegAddrWidth-1:0] rdAddrA,
    input  logic [wiscPkg::RegAddrWidth-1:0] rdAddrB,
    output logic [wiscPkg::DataWidth-1:0]    rdDataA,
    output logic [wiscPkg::DataWidth-1:0]    rdDataB,
    input  logic [wiscPkg::RegAddrWidth-1:0] wrAddr,
    input  logic [wiscPkg::DataWidth-1:0]    wrData,
    input  logic                             wrEn
);

    logic [wiscPkg::DataWidth-1:0] regs [wiscPkg::NumRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < wiscPkg::NumRegs; i++)
                regs[i] <= '0;
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA]; // r0 is hardwired
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: hdl/writeBack.sv
`timescale 1ns/1ps

module writeBack (
    input  logic [wiscPkg::OpcodeWidth-1:0] opcode,
    input  logic                          regWrite,
    input  logic                          memToReg,
    input  logic                          memHalf,
    input  logic                          pcSave,
    input  logic                          stall,
    input  logic [wiscPkg::DataWidth-1:0] aluResult,
    input  logic [wiscPkg::DataWidth-1:0] memData,
    input  logic [wiscPkg::DataWidth-1:0] oldValue,
    input  logic [7:0]                    imm8,
    input  logic [wiscPkg::DataWidth-1:0] pcPlus2,
    output logic [wiscPkg::DataWidth-1:0] wrData,
    output logic                          wrEn
);

    logic [wiscPkg::DataWidth-1:0] byteMerge;

    // LHB when bit 0 set, else LLB
    assign byteMerge = opcode[0] ? {imm8, oldValue[7:0]} : {oldValue[15:8], imm8};

    assign wrData = memToReg ? memData   :
                    pcSave   ? pcPlus2   :
                    memHalf  ? byteMerge : aluResult;

    assign wrEn = (regWrite | pcSave) & ~stall;

endmodule

// File: hdl/apbDataPort.sv
`timescale 1ns/1ps

module apbDataPort (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          memRead,
    input  logic                          memWrite,
    input  logic [wiscPkg::DataWidth-1:0] addr,
    input  logic [wiscPkg::DataWidth-1:0] storeData,
    output logic [wiscPkg::DataWidth-1:0] paddr,
    output logic                          psel,
    output logic                          penable,
    output logic                          pwrite,
    output logic [wiscPkg::DataWidth-1:0] pwdata,
    input  logic [wiscPkg::DataWidth-1:0] prdata,
    input  logic                          pready,
    output logic [wiscPkg::DataWidth-1:0] memData,
    output logic                          stall,
    output logic                          memDone
);

    typedef enum logic [1:0] {Idle, Setup, Access} apbStateT;

    apbStateT state;
    apbStateT phase;

    // Setup overlaps the instruction's first cycle
    always_comb begin
        if (state == Access)
            phase = Access;
        else
            phase = memRead ? Setup : Idle;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            state <= Idle;
        else if (phase == Setup)
            state <= Access;
        else if (phase == Access && pready)
            state <= Idle;
    end

    assign psel    = (phase != Idle);
    assign penable = (phase == Access);
    assign pwrite  = psel & memWrite;
    assign paddr   = addr;      // Held stable by the stalled PC
    assign pwdata  = storeData;
    assign memDone = penable & pready;
    assign stall   = psel & ~memDone;
    assign memData = prdata;

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [wiscPkg::OpcodeWidth-1:0] opcode,
    input  logic [wiscPkg::DataWidth-1:0] srcA,
    input  logic [wiscPkg::DataWidth-1:0] srcB,
    input  logic [3:0]                    imm4,
    input  logic                          aluSrc,
    input  logic                          memRead,
    input  logic                          stall,
    input  logic                          halted,
    output logic [wiscPkg::DataWidth-1:0] aluResult,
    output logic [2:0]                    flags
);

    localparam int W = wiscPkg::DataWidth;

    logic [W-1:0] opB;
    logic [W-1:0] sum;
    logic [W-1:0] diff;
    logic [W-1:0] nibbles;
    logic         ovfAdd;
    logic         ovfSub;
    logic         isZero;

    assign opB  = aluSrc ? srcB : {{(W-4){1'b0}}, imm4};
    assign sum  = srcA + opB;
    assign diff = srcA - opB;
    assign ovfAdd = (srcA[W-1] == opB[W-1]) && (sum[W-1] != srcA[W-1]);
    assign ovfSub = (srcA[W-1] != opB[W-1]) && (diff[W-1] != srcA[W-1]);

    always_comb begin
        logic signed [4:0] nibSum;
        for (int i = 0; i < W / 4; i++) begin
            nibSum = $signed({srcA[4*i+3], srcA[4*i+:4]}) + $signed({opB[4*i+3], opB[4*i+:4]});
            if (nibSum > 5'sd7)
                nibbles[4*i+:4] = 4'h7;
            else if (nibSum < -5'sd8)
                nibbles[4*i+:4] = 4'h8;
            else
                nibbles[4*i+:4] = nibSum[3:0];
        end
    end

    always_comb begin
        if (memRead) begin
            aluResult = srcA + {{(W-5){1'b0}}, imm4, 1'b0}; // Word address rs + 2*imm4
        end else begin
            case (opcode)
                wiscPkg::OpAdd:    aluResult = ovfAdd ? {srcA[W-1], {(W-1){~srcA[W-1]}}} : sum;
                wiscPkg::OpSub:    aluResult = ovfSub ? {srcA[W-1], {(W-1){~srcA[W-1]}}} : diff;
                wiscPkg::OpXor:    aluResult = srcA ^ opB;
                wiscPkg::OpAnd:    aluResult = srcA & opB;
                wiscPkg::OpSll:    aluResult = srcA << imm4;
                wiscPkg::OpSra:    aluResult = $signed(srcA) >>> imm4;
                wiscPkg::OpRor:    aluResult = (srcA >> imm4) | (srcA << (W - imm4));
                wiscPkg::OpPaddsb: aluResult = nibbles;
                default:           aluResult = '0;
            endcase
        end
    end

    assign isZero = (aluResult == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else if (!stall && !halted) begin
            case (opcode)
                wiscPkg::OpAdd: begin
                    flags[wiscPkg::FlagZ] <= isZero;
                    flags[wiscPkg::FlagN] <= aluResult[W-1];
                    flags[wiscPkg::FlagV] <= ovfAdd;
                end
                wiscPkg::OpSub: begin
                    flags[wiscPkg::FlagZ] <= isZero;
                    flags[wiscPkg::FlagN] <= aluResult[W-1];
                    flags[wiscPkg::FlagV] <= ovfSub;
                end
                wiscPkg::OpXor, wiscPkg::OpSll, wiscPkg::OpSra, wiscPkg::OpRor:
                    flags[wiscPkg::FlagZ] <= isZero; // Z only
                default: ;
            endcase
        end
    end

endmodule

// File: hdl/control.sv
`timescale 1ns/1ps

module control (
    input  logic [wiscPkg::OpcodeWidth-1:0] opcode,
    output logic regDst,
    output logic branch,
    output logic branchReg,
    output logic memToReg,
    output logic memRead,
    output logic aluSrc,
    output logic memWrite,
    output logic memHalf,
    output logic regWrite,
    output logic pcSave
);

    always_comb begin
        regDst    = 1'b0;
        branch    = 1'b0;
        branchReg = 1'b0;
        memToReg  = 1'b0;
        memRead   = 1'b0;
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        memHalf   = 1'b0;
        regWrite  = 1'b0;
        pcSave    = 1'b0;
        case (opcode)
            wiscPkg::OpAdd, wiscPkg::OpSub, wiscPkg::OpXor, wiscPkg::OpAnd,
            wiscPkg::OpPaddsb: begin
                regDst   = 1'b1; // Second operand is rt
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            wiscPkg::OpSll, wiscPkg::OpSra, wiscPkg::OpRor: begin
                regDst   = 1'b1;
                regWrite = 1'b1; // Shift amount from imm4
            end
            wiscPkg::OpLw: begin
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            wiscPkg::OpSw: begin
                memRead  = 1'b1; // Also set for stores
                memWrite = 1'b1;
            end
            wiscPkg::OpLlb, wiscPkg::OpLhb: begin
                memHalf  = 1'b1; // Old rd value read on port B
                regWrite = 1'b1;
            end
            wiscPkg::OpB: begin
                branch = 1'b1;
            end
            wiscPkg::OpBr: begin
                branch    = 1'b1;
                branchReg = 1'b1;
            end
            wiscPkg::OpPcs: begin
                pcSave = 1'b1;
            end
            default: ; // HLT decodes to no strobes
        endcase
    end

endmodule

// File: hdl/wiscPkg.sv
package wiscPkg;

    localparam int DataWidth    = 16;
    localparam int NumRegs      = 16;
    localparam int RegAddrWidth = 4;
    localparam int OpcodeWidth  = 4;

    localparam logic [OpcodeWidth-1:0] OpAdd    = 4'd0;
    localparam logic [OpcodeWidth-1:0] OpSub    = 4'd1;
    localparam logic [OpcodeWidth-1:0] OpXor    = 4'd2;
    localparam logic [OpcodeWidth-1:0] OpAnd    = 4'd3;
    localparam logic [OpcodeWidth-1:0] OpSll    = 4'd4;
    localparam logic [OpcodeWidth-1:0] OpSra    = 4'd5;
    localparam logic [OpcodeWidth-1:0] OpRor    = 4'd6;
    localparam logic [OpcodeWidth-1:0] OpPaddsb = 4'd7;
    localparam logic [OpcodeWidth-1:0] OpLw     = 4'd8;
    localparam logic [OpcodeWidth-1:0] OpSw     = 4'd9;
    localparam logic [OpcodeWidth-1:0] OpLlb    = 4'd10;
    localparam logic [OpcodeWidth-1:0] OpLhb    = 4'd11;
    localparam logic [OpcodeWidth-1:0] OpB      = 4'd12;
    localparam logic [OpcodeWidth-1:0] OpBr     = 4'd13;
    localparam logic [OpcodeWidth-1:0] OpPcs    = 4'd14;
    localparam logic [OpcodeWidth-1:0] OpHlt    = 4'd15;

    localparam logic [2:0] CcNe     = 3'd0;
    localparam logic [2:0] CcEq     = 3'd1;
    localparam logic [2:0] CcGt     = 3'd2;
    localparam logic [2:0] CcLt     = 3'd3;
    localparam logic [2:0] CcGe     = 3'd4;
    localparam logic [2:0] CcLe     = 3'd5;
    localparam logic [2:0] CcOv     = 3'd6;
    localparam logic [2:0] CcAlways = 3'd7;

    // Bit positions in the flag register
    localparam int FlagN = 0;
    localparam int FlagV = 1;
    localparam int FlagZ = 2;

endpackage
